// File: src/dmb_config.svh
`ifndef DMB_CONFIG_SVH
`define DMB_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////

`define DMB_DATA_W      16
`define DMB_ADDR_W      16
`define DMB_CMD_W       8
`define DMB_DEV_W       4

////////////////////////////////////////////////////////////////////////////
// JTAG engines and timing
////////////////////////////////////////////////////////////////////////////

// FE boards, MB controller, controller PROM, bus PROM
`define DMB_NUM_JTAG    4
// Free-running divider, one period of the slowest TCK
`define DMB_CLKCNT_W    5
// Init phase length in slowest-TCK ticks
`define DMB_INIT_TICKS  32

// Returned in the upper byte of the status word
`define DMB_IDENT       8'hD7

`endif

// File: src/dmb_bus_pkg.sv
`include "dmb_config.svh"

package dmb_bus_pkg;

	// Data word on the crate bus
	typedef logic [`DMB_DATA_W-1:0] bus_data_t;

	// Full register address
	typedef logic [`DMB_ADDR_W-1:0] bus_addr_t;

	// Address bits 15 to 12
	typedef logic [`DMB_DEV_W-1:0] dev_num_t;

	// Address bits 7 to 0, count nibble over op nibble
	typedef logic [`DMB_CMD_W-1:0] cmd_t;

	// One bit per JTAG engine
	typedef logic [`DMB_NUM_JTAG-1:0] jtag_sel_t;

endpackage

// File: src/dmb_jtag_pkg.sv
package dmb_jtag_pkg;

	// Lower nibble of the command field
	typedef enum logic [3:0] {
		SHIFT_DATA      = 4'd0,
		SHIFT_DATA_EXIT = 4'd1,
		SHIFT_TMS       = 4'd2,
		READ_CAPTURE    = 4'd3
	} jtag_op_e;

	// Upper nibble of the command field, bits to shift minus one
	typedef logic [3:0] bit_cnt_t;

	// Shift engine
	typedef enum logic [1:0] {
		IDLE,
		LOW_PHASE,
		HIGH_PHASE,
		DONE
	} jtag_state_e;

endpackage

// File: src/jtag_req_if.sv
`timescale 1ns/1ps

interface jtag_req_if
	import dmb_bus_pkg::*;
;
	// Single-cycle strobe of a decoded access
	logic      req_valid;
	// One-hot engine select
	jtag_sel_t req_sel;
	logic      req_write;
	cmd_t      req_cmd;
	bus_data_t req_data;

	modport source (
		output req_valid,
		output req_sel,
		output req_write,
		output req_cmd,
		output req_data
	);

	modport sink (
		input req_valid,
		input req_sel,
		input req_write,
		input req_cmd,
		input req_data
	);

endinterface

// File: src/clk_en_gen.sv
`timescale 1ns/1ps
`include "dmb_config.svh"

module clk_en_gen
	import dmb_bus_pkg::*;
(
	input  logic      fastclk,
	input  logic      jtimer_clr,
	output jtag_sel_t tck_en_o,
	output jtag_sel_t neg_tck_en_o,
	output logic      init_active_o
);

	localparam int INIT_CNT_W = $clog2(`DMB_INIT_TICKS + 1);
	localparam logic [INIT_CNT_W-1:0] INIT_LAST = `DMB_INIT_TICKS;
	localparam logic [`DMB_CLKCNT_W-1:0] CNT_HALF = 1 << (`DMB_CLKCNT_W - 1);

	logic [`DMB_CLKCNT_W-1:0] clkcnt;
	logic [INIT_CNT_W-1:0]    init_cnt;
	logic mid_en;
	logic neg_mid_en;
	logic slow_en;
	logic neg_slow_en;
	logic slow2_en;
	logic neg_slow2_en;

	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			clkcnt       <= '0;
			mid_en       <= 1'b0;
			neg_mid_en   <= 1'b0;
			slow_en      <= 1'b0;
			neg_slow_en  <= 1'b0;
			slow2_en     <= 1'b0;
			neg_slow2_en <= 1'b0;
		end else begin
			clkcnt       <= clkcnt + 1'b1;
			// 4-cycle rate
			mid_en       <= (clkcnt[1:0] == 2'd0);
			neg_mid_en   <= (clkcnt[1:0] == 2'd2);
			// 16-cycle rate
			slow_en      <= (clkcnt[3:0] == 4'd0);
			neg_slow_en  <= (clkcnt[3:0] == 4'd8);
			// 32-cycle rate, a full counter wrap
			slow2_en     <= (clkcnt == '0);
			neg_slow2_en <= (clkcnt == CNT_HALF);
		end
	end

	// Engine order: FE boards, MB controller, controller PROM, bus PROM
	assign tck_en_o     = {slow2_en, slow2_en, mid_en, slow_en};
	assign neg_tck_en_o = {neg_slow2_en, neg_slow2_en, neg_mid_en, neg_slow_en};

	// Init phase counts slow ticks and then stops
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr)
			init_cnt <= '0;
		else if (slow2_en && init_active_o)
			init_cnt <= init_cnt + 1'b1;
	end

	assign init_active_o = (init_cnt != INIT_LAST);

endmodule

// File: src/vme_cmd_decode.sv
`timescale 1ns/1ps
`include "dmb_config.svh"

module vme_cmd_decode
	import dmb_bus_pkg::*;
(
	input  logic       fastclk,
	input  logic       jtimer_clr,
	input  logic       ds_i,
	input  logic       we_i,
	input  bus_addr_t  addr_i,
	input  bus_data_t  wdata_i,
	input  logic       dtack_i,
	jtag_req_if.source req,
	output logic       stat_rd_o
);

	logic      ds_q;
	logic      busy_q;
	logic      strobe;
	dev_num_t  dev;
	cmd_t      cmd;
	jtag_sel_t sel;

	////////////////////////////////////////////////////////////////////////////
	// Address split
	////////////////////////////////////////////////////////////////////////////

	assign dev = addr_i[`DMB_ADDR_W-1 -: `DMB_DEV_W];
	assign cmd = addr_i[`DMB_CMD_W-1:0];

	// Devices 1 to 4 map onto engines 0 to 3
	always_comb begin
		sel = '0;
		for (int k = 0; k < `DMB_NUM_JTAG; k++) begin
			if (dev == dev_num_t'(k + 1))
				sel[k] = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Strobe detection
	////////////////////////////////////////////////////////////////////////////

	// A new access only once the previous one has fully ended
	assign strobe = ds_i & ~ds_q & ~busy_q;

	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			ds_q          <= 1'b0;
			busy_q        <= 1'b0;
			req.req_valid <= 1'b0;
			stat_rd_o     <= 1'b0;
		end else begin
			ds_q          <= ds_i;
			req.req_valid <= strobe & (|sel);
			stat_rd_o     <= strobe & (dev == '0);
			if (strobe)
				busy_q <= 1'b1;
			else if (!ds_i && !dtack_i)
				busy_q <= 1'b0;
		end
	end

	// Request fields, valid alongside req_valid
	always_ff @(posedge fastclk) begin
		if (strobe) begin
			req.req_sel   <= sel;
			req.req_write <= we_i;
			req.req_cmd   <= cmd;
			req.req_data  <= wdata_i;
		end
	end

endmodule

// File: src/jtag_port.sv
`timescale 1ns/1ps
`include "dmb_config.svh"

module jtag_port
	import dmb_bus_pkg::*;
	import dmb_jtag_pkg::*;
#(
	parameter int PORT_IDX = 0
) (
	input  logic      fastclk,
	input  logic      jtimer_clr,
	input  logic      tck_en_i,
	input  logic      neg_tck_en_i,
	input  logic      init_active_i,
	jtag_req_if.sink  req,
	input  logic      tdo_i,
	output logic      tck_o,
	output logic      tms_o,
	output logic      tdi_o,
	output logic      done_o,
	output bus_data_t rdata_o
);

	jtag_state_e state_q;
	jtag_op_e    op_q;
	jtag_op_e    new_op;
	bit_cnt_t    cnt_q;
	bit_cnt_t    idx_q;
	bus_data_t   shift_q;
	bus_data_t   capture_q;
	logic        write_q;
	logic        pend_q;
	logic        new_req;
	logic        tck_q;
	logic        tms_q;
	logic        tdi_q;

	// Only writes of the three shift ops drive the chain
	function automatic logic is_shift(input jtag_op_e op, input logic wr);
		return wr && (op == SHIFT_DATA || op == SHIFT_DATA_EXIT || op == SHIFT_TMS);
	endfunction

	assign new_req = req.req_valid & req.req_sel[PORT_IDX];
	assign new_op  = jtag_op_e'(req.req_cmd[3:0]);

	// Latched request, shifted out LSB first
	always_ff @(posedge fastclk) begin
		if (state_q == IDLE && new_req) begin
			op_q    <= new_op;
			cnt_q   <= req.req_cmd[7:4];
			write_q <= req.req_write;
			shift_q <= req.req_data;
		end else if (state_q == HIGH_PHASE && tck_en_i) begin
			shift_q <= shift_q >> 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Shift FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			state_q   <= IDLE;
			pend_q    <= 1'b0;
			idx_q     <= '0;
			tck_q     <= 1'b0;
			tms_q     <= 1'b1;
			tdi_q     <= 1'b0;
			capture_q <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					// Free-running TCK with TMS high while init lasts
					if (neg_tck_en_i) begin
						tck_q <= 1'b0;
					end else if (tck_en_i && init_active_i) begin
						tck_q <= 1'b1;
						tms_q <= 1'b1;
						tdi_q <= 1'b0;
					end
					idx_q <= '0;
					if (new_req) begin
						if (init_active_i)
							pend_q <= 1'b1;
						else
							state_q <= is_shift(new_op, req.req_write) ? LOW_PHASE : DONE;
					end else if (pend_q && !init_active_i) begin
						pend_q  <= 1'b0;
						state_q <= is_shift(op_q, write_q) ? LOW_PHASE : DONE;
					end
				end
				LOW_PHASE: begin
					if (neg_tck_en_i) begin
						tck_q <= 1'b0;
						case (op_q)
							SHIFT_TMS: begin
								tms_q <= shift_q[0];
								tdi_q <= 1'b0;
							end
							SHIFT_DATA_EXIT: begin
								tms_q <= (idx_q == cnt_q);
								tdi_q <= shift_q[0];
							end
							default: begin
								tms_q <= 1'b0;
								tdi_q <= shift_q[0];
							end
						endcase
						state_q <= HIGH_PHASE;
					end
				end
				HIGH_PHASE: begin
					if (tck_en_i) begin
						tck_q     <= 1'b1;
						capture_q <= {tdo_i, capture_q[`DMB_DATA_W-1:1]};
						if (idx_q == cnt_q) begin
							state_q <= DONE;
						end else begin
							idx_q   <= idx_q + 1'b1;
							state_q <= LOW_PHASE;
						end
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	assign tck_o   = tck_q;
	assign tms_o   = tms_q;
	assign tdi_o   = tdi_q;
	assign done_o  = (state_q == DONE);
	assign rdata_o = capture_q;

endmodule

// File: src/readback_mux.sv
`timescale 1ns/1ps
`include "dmb_config.svh"

module readback_mux
	import dmb_bus_pkg::*;
(
	input  logic      fastclk,
	input  logic      jtimer_clr,
	input  logic      ds_i,
	input  jtag_sel_t done_i,
	input  bus_data_t port_rdata_i [`DMB_NUM_JTAG],
	input  logic      stat_rd_i,
	input  logic      init_active_i,
	output logic      dtack_o,
	output bus_data_t rdata_o
);

	bus_data_t stat_word;
	bus_data_t port_word;

	// Ident byte on top, init flag in bit 4
	assign stat_word = {`DMB_IDENT, 3'b000, init_active_i, 4'h0};

	// At most one engine finishes per access
	always_comb begin
		port_word = '0;
		for (int k = 0; k < `DMB_NUM_JTAG; k++) begin
			if (done_i[k])
				port_word = port_word | port_rdata_i[k];
		end
	end

	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr)
			dtack_o <= 1'b0;
		else if (stat_rd_i || (|done_i))
			dtack_o <= 1'b1;
		else if (!ds_i)
			dtack_o <= 1'b0;
	end

	// Held steady until the next access completes
	always_ff @(posedge fastclk) begin
		if (stat_rd_i)
			rdata_o <= stat_word;
		else if (|done_i)
			rdata_o <= port_word;
	end

endmodule

// File: src/dmb_ctrl_top.sv
`timescale 1ns/1ps
`include "dmb_config.svh"

module dmb_ctrl_top
	import dmb_bus_pkg::*;
(
	input  logic      fastclk,
	input  logic      jtimer_clr_i,
	input  logic      ds_i,
	input  logic      we_i,
	input  bus_addr_t addr_i,
	input  bus_data_t wdata_i,
	output logic      dtack_o,
	output bus_data_t rdata_o,
	input  jtag_sel_t tdo_i,
	output jtag_sel_t tck_o,
	output jtag_sel_t tms_o,
	output jtag_sel_t tdi_o
);

	jtag_sel_t tck_en;
	jtag_sel_t neg_tck_en;
	jtag_sel_t port_done;
	bus_data_t port_rdata [`DMB_NUM_JTAG];
	logic      init_active;
	logic      stat_rd;

	jtag_req_if req_bus ();

	clk_en_gen u_clk_en (
		.fastclk       (fastclk),
		.jtimer_clr    (jtimer_clr_i),
		.tck_en_o      (tck_en),
		.neg_tck_en_o  (neg_tck_en),
		.init_active_o (init_active)
	);

	vme_cmd_decode u_decode (
		.fastclk    (fastclk),
		.jtimer_clr (jtimer_clr_i),
		.ds_i       (ds_i),
		.we_i       (we_i),
		.addr_i     (addr_i),
		.wdata_i    (wdata_i),
		.dtack_i    (dtack_o),
		.req        (req_bus),
		.stat_rd_o  (stat_rd)
	);

	////////////////////////////////////////////////////////////////////////////
	// Devices 1 to 4, one engine per chain
	////////////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < `DMB_NUM_JTAG; g++) begin : g_port
		jtag_port #(
			.PORT_IDX (g)
		) u_port (
			.fastclk       (fastclk),
			.jtimer_clr    (jtimer_clr_i),
			.tck_en_i      (tck_en[g]),
			.neg_tck_en_i  (neg_tck_en[g]),
			.init_active_i (init_active),
			.req           (req_bus),
			.tdo_i         (tdo_i[g]),
			.tck_o         (tck_o[g]),
			.tms_o         (tms_o[g]),
			.tdi_o         (tdi_o[g]),
			.done_o        (port_done[g]),
			.rdata_o       (port_rdata[g])
		);
	end

	readback_mux u_readback (
		.fastclk       (fastclk),
		.jtimer_clr    (jtimer_clr_i),
		.ds_i          (ds_i),
		.done_i        (port_done),
		.port_rdata_i  (port_rdata),
		.stat_rd_i     (stat_rd),
		.init_active_i (init_active),
		.dtack_o       (dtack_o),
		.rdata_o       (rdata_o)
	);

endmodule

// File: testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int HALF_PERIOD_NS = 10,
	parameter int RESET_CYCLES   = 5
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;
	end

	// 20 ns fastclk
	always #HALF_PERIOD_NS clk_o = ~clk_o;

endmodule

// File: testbench/tb_dmb_ctrl.sv
`timescale 1ns/1ps

module tb_dmb_ctrl
	import dmb_bus_pkg::*;
	import dmb_jtag_pkg::*;
;

	localparam int        NUM_ENG       = 4;
	localparam int        ACK_TIMEOUT   = 4000;
	localparam int        RESET_TIMEOUT = 100;
	localparam int        POLL_LIMIT    = 1000;
	localparam int        UNMAPPED_WAIT = 200;
	localparam logic [7:0] IDENT        = 8'hD7;

	logic      fastclk;
	logic      jtimer_clr;
	logic      ds;
	logic      we;
	bus_addr_t addr;
	bus_data_t wdata;
	logic      dtack;
	bus_data_t rdata;
	jtag_sel_t tdo;
	jtag_sel_t tck;
	jtag_sel_t tms;
	jtag_sel_t tdi;

	int    err_count       = 0;
	int    check_count     = 0;
	int    test_count      = 0;
	int    test_fail_count = 0;
	int    test_err_start  = 0;
	string test_name;
	bit    timeout_hit     = 1'b0;

	// Expected read data, one entry per read access
	bus_data_t exp_q[$];
	bus_data_t mask_q[$];
	logic      dtack_prev = 1'b0;

	// TCK edge monitor state
	bit        mon_on = 1'b0;
	int        mon_engine = 0;
	int        rise_cnt = 0;
	bus_data_t tms_rise_mask = '0;
	bit        tdi_high_seen = 1'b0;
	jtag_sel_t tck_prev = '0;

	tb_clkgen #(
		.HALF_PERIOD_NS (10),
		.RESET_CYCLES   (5)
	) clkgen0 (
		.clk_o (fastclk),
		.rst_o (jtimer_clr)
	);

	dmb_ctrl_top dut0 (
		.fastclk      (fastclk),
		.jtimer_clr_i (jtimer_clr),
		.ds_i         (ds),
		.we_i         (we),
		.addr_i       (addr),
		.wdata_i      (wdata),
		.dtack_o      (dtack),
		.rdata_o      (rdata),
		.tdo_i        (tdo),
		.tck_o        (tck),
		.tms_o        (tms),
		.tdi_o        (tdi)
	);

	// Every chain loops TDI straight back to TDO
	assign tdo = tdi;

	////////////////////////////////////////////////////////////////////////////
	// Reference model and helpers
	////////////////////////////////////////////////////////////////////////////

	// n bits shifted into a cleared register end up at the top of the word
	function automatic bus_data_t expected_capture(input bus_data_t d, input int nbits);
		bus_data_t keep;
		keep = (nbits >= 16) ? 16'hFFFF : bus_data_t'((32'd1 << nbits) - 32'd1);
		return bus_data_t'((d & keep) << (16 - nbits));
	endfunction

	function automatic bus_addr_t engine_addr(input int eng, input int nbits, input jtag_op_e op);
		return {dev_num_t'(eng + 1), 4'h0, bit_cnt_t'(nbits - 1), 4'(op)};
	endfunction

	task automatic report_timeout(input string what);
		$display("Timeout at %t while waiting for %s", $time, what);
		err_count++;
		timeout_hit = 1'b1;
		// Park here, the main process ends the run
		forever @(posedge fastclk);
	endtask

	task automatic compare_value(input string sig, input int got, input int exp);
		check_count++;
		assert (got == exp) else begin
			$display("FAIL t=%t %s expected %0h got %0h", $time, sig, exp, got);
			err_count++;
		end
	endtask

	task automatic start_test(input string name);
		test_name      = name;
		test_err_start = err_count;
		test_count++;
	endtask

	task automatic finish_test();
		if (err_count == test_err_start) begin
			$display("test %-26s passed", test_name);
		end else begin
			$display("test %-26s failed", test_name);
			test_fail_count++;
		end
	endtask

	// Full strobe/acknowledge cycle, returns the read data
	task automatic bus_access(input bus_addr_t a, input logic w, input bus_data_t d,
			output bus_data_t rd);
		int n;
		@(posedge fastclk);
		addr  <= a;
		we    <= w;
		wdata <= d;
		ds    <= 1'b1;
		n = 0;
		@(negedge fastclk);
		while (!dtack) begin
			if (n == ACK_TIMEOUT)
				report_timeout($sformatf("dtack_o on address %h", a));
			n++;
			@(negedge fastclk);
		end
		rd = rdata;
		@(posedge fastclk);
		ds <= 1'b0;
		@(negedge fastclk);
		// Acknowledge must still be up right after the strobe falls
		compare_value("dtack_o after ds_i fell", int'(dtack), 1);
		n = 0;
		while (dtack) begin
			if (n == ACK_TIMEOUT)
				report_timeout("dtack_o to drop");
			n++;
			@(negedge fastclk);
		end
	endtask

	task automatic read_expect(input bus_addr_t a, input bus_data_t exp,
			input bus_data_t mask, output bus_data_t rd);
		exp_q.push_back(exp);
		mask_q.push_back(mask);
		bus_access(a, 1'b0, '0, rd);
	endtask

	task automatic write_reg(input bus_addr_t a, input bus_data_t d);
		bus_data_t unused;
		bus_access(a, 1'b1, d, unused);
	endtask

	task automatic arm_monitor(input int eng);
		mon_engine    = eng;
		rise_cnt      = 0;
		tms_rise_mask = '0;
		tdi_high_seen = 1'b0;
		mon_on        = 1'b1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare process and TCK monitor
	////////////////////////////////////////////////////////////////////////////

	always @(negedge fastclk) begin
		bus_data_t exp_val;
		bus_data_t exp_mask;
		if (dtack && !dtack_prev && !we) begin
			if (exp_q.size() == 0) begin
				$display("ERROR t=%t read acknowledged with no expected value pending", $time);
				err_count++;
			end else begin
				exp_val  = exp_q.pop_front();
				exp_mask = mask_q.pop_front();
				check_count++;
				assert ((rdata & exp_mask) == (exp_val & exp_mask)) else begin
					$display("FAIL t=%t rdata_o expected %h got %h (mask %h)",
						$time, exp_val, rdata, exp_mask);
					err_count++;
				end
			end
		end
		dtack_prev = dtack;
	end

	// TMS and TDI are stable while TCK is high
	always @(negedge fastclk) begin
		if (mon_on && tck[mon_engine] && !tck_prev[mon_engine]) begin
			if (tms[mon_engine] && rise_cnt < 16)
				tms_rise_mask[rise_cnt] = 1'b1;
			if (tdi[mon_engine])
				tdi_high_seen = 1'b1;
			rise_cnt++;
		end
		tck_prev = tck;
	end

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic reset_and_status();
		int n;
		bus_data_t rd;
		start_test("reset and init status");
		n = 0;
		@(negedge fastclk);
		while (jtimer_clr) begin
			if (n == RESET_TIMEOUT)
				report_timeout("reset release");
			n++;
			@(negedge fastclk);
		end
		compare_value("tms_o after reset", int'(tms), 4'hF);
		compare_value("tdi_o after reset", int'(tdi), 0);
		compare_value("dtack_o after reset", int'(dtack), 0);
		read_expect(16'h0000, {IDENT, 8'h10}, 16'hFFFF, rd);
		// Ident only while the init flag may still change
		n = 0;
		while (rd[4]) begin
			if (n == POLL_LIMIT)
				report_timeout("the init flag to clear");
			n++;
			read_expect(16'h0000, {IDENT, 8'h00}, 16'hFF00, rd);
		end
		read_expect(16'h0000, {IDENT, 8'h00}, 16'hFFFF, rd);
		finish_test();
	endtask

	task automatic data_roundtrip();
		bus_data_t d;
		bus_data_t rd;
		for (int e = 0; e < NUM_ENG; e++) begin
			start_test($sformatf("16-bit roundtrip engine %0d", e));
			d = bus_data_t'($urandom);
			write_reg(engine_addr(e, 16, SHIFT_DATA), d);
			read_expect(engine_addr(e, 1, READ_CAPTURE), d, 16'hFFFF, rd);
			finish_test();
		end
	endtask

	task automatic short_shift();
		bus_data_t d;
		bus_data_t rd;
		int n;
		for (int e = 0; e < NUM_ENG; e++) begin
			start_test($sformatf("short shift engine %0d", e));
			n = 1 + int'($urandom % 15);
			d = bus_data_t'($urandom);
			write_reg(engine_addr(e, 16, SHIFT_DATA), 16'h0000);
			write_reg(engine_addr(e, n, SHIFT_DATA), d);
			read_expect(engine_addr(e, 1, READ_CAPTURE), expected_capture(d, n), 16'hFFFF, rd);
			finish_test();
		end
	endtask

	task automatic tms_and_exit_shift();
		int n;
		for (int e = 0; e < NUM_ENG; e++) begin
			start_test($sformatf("TMS and exit shift engine %0d", e));
			n = 2 + int'($urandom % 15);
			arm_monitor(e);
			write_reg(engine_addr(e, n, SHIFT_TMS), bus_data_t'($urandom));
			mon_on = 1'b0;
			compare_value($sformatf("tck_o[%0d] rises in SHIFT_TMS", e), rise_cnt, n);
			compare_value($sformatf("tdi_o[%0d] high in SHIFT_TMS", e), int'(tdi_high_seen), 0);
			arm_monitor(e);
			write_reg(engine_addr(e, n, SHIFT_DATA_EXIT), bus_data_t'($urandom));
			mon_on = 1'b0;
			compare_value($sformatf("tck_o[%0d] rises in SHIFT_DATA_EXIT", e), rise_cnt, n);
			compare_value($sformatf("tms_o[%0d] mask in SHIFT_DATA_EXIT", e),
				int'(tms_rise_mask), 1 << (n - 1));
			finish_test();
		end
	endtask

	task automatic unmapped_device();
		dev_num_t dev;
		bus_data_t rd;
		bit acked;
		start_test("unmapped device");
		dev   = dev_num_t'(5 + ($urandom % 11));
		acked = 1'b0;
		@(posedge fastclk);
		addr <= {dev, 12'h0F3};
		we   <= 1'b0;
		ds   <= 1'b1;
		for (int n = 0; n < UNMAPPED_WAIT; n++) begin
			@(negedge fastclk);
			if (dtack)
				acked = 1'b1;
		end
		check_count++;
		assert (!acked) else begin
			$display("ERROR t=%t unmapped device %0d was acknowledged", $time, dev);
			err_count++;
		end
		@(posedge fastclk);
		ds <= 1'b0;
		repeat (2) @(posedge fastclk);
		// Decoder must accept the next access
		read_expect(16'h0000, {IDENT, 8'h00}, 16'hFFFF, rd);
		finish_test();
	endtask

	task automatic run_tests();
		reset_and_status();
		data_roundtrip();
		short_shift();
		tms_and_exit_shift();
		unmapped_device();
		if (exp_q.size() != 0) begin
			$display("ERROR %0d expected reads were never acknowledged", exp_q.size());
			err_count++;
		end
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		void'($urandom(32'h207a));
		ds    <= 1'b0;
		we    <= 1'b0;
		addr  <= '0;
		wdata <= '0;
		fork
			run_tests();
			wait (timeout_hit);
		join_any
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			test_count, test_fail_count, check_count, err_count);
		if (err_count == 0 && !timeout_hit) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+src
src/dmb_bus_pkg.sv
src/dmb_jtag_pkg.sv
src/jtag_req_if.sv
src/clk_en_gen.sv
src/vme_cmd_decode.sv
src/jtag_port.sv
src/readback_mux.sv
src/dmb_ctrl_top.sv
testbench/tb_clkgen.sv
testbench/tb_dmb_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build the board-controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dmb_ctrl -f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_dmb_ctrl 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
